// File: logic/commu_frame_pkg.sv
// frame format: word type, header pattern, default header and payload lengths
package commu_frame_pkg;

	// --------------------
	// word format
	// --------------------

	// bits per serial word
	localparam int WORD_BITS = 16;

	// one word on data_tx and on the payload port
	typedef logic [WORD_BITS-1:0] word_t;

	// --------------------
	// frame layout
	// --------------------

	// header words are all ones
	localparam word_t HEAD_PATTERN = 16'hFFFF;

	// words in the fixed header
	localparam int HEAD_WORDS_DEF = 10;

	// payload words fetched from the source per frame
	localparam int DATA_WORDS_DEF = 4;

endpackage

// File: logic/commu_link_pkg.sv
// serial link: bit timing, word timeout default, transmitter source select
package commu_link_pkg;

	// --------------------
	// line timing
	// --------------------

	// clock cycles per serial bit
	localparam int BIT_CYCLES_DEF = 4;

	// cycles in the wait state before a word is given up
	localparam logic [15:0] TIMEOUT_DEF = 16'd192;

	// --------------------
	// source select
	// --------------------

	// which sender owns the transmitter
	typedef enum logic {
		SRC_HEAD = 1'b0,
		SRC_DATA = 1'b1
	} tx_src_t;

endpackage

// File: logic/commu_head.sv
// header sender: header words over fire/done with a wait timeout per word
module commu_head import commu_frame_pkg::*, commu_link_pkg::*; #(
	parameter int          HEAD_WORDS = HEAD_WORDS_DEF,
	parameter logic [15:0] TIMEOUT    = TIMEOUT_DEF
) (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  fire_head,
	output logic  done_head,
	output logic  head_timeout,
	output logic  fire_tx,
	input  logic  done_tx,
	output word_t data_tx
);

	localparam int CW = $clog2(HEAD_WORDS + 1);

	typedef enum logic [2:0] {
		S_IDLE = 3'h0,
		S_HEAD = 3'h1,
		S_FIRE = 3'h2,
		S_WAIT = 3'h3,
		S_NEXT = 3'h4,
		S_DONE = 3'h7
	} state_t;

	state_t state;
	logic [CW-1:0] cnt_head;
	logic [15:0] cnt_wait;
	logic finish_head;
	logic timeout_tx;

	// --------------------
	// main fsm
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: state <= fire_head ? S_HEAD : S_IDLE;
				S_HEAD: state <= S_FIRE;
				S_FIRE: state <= S_WAIT;
				S_WAIT: state <= (done_tx || timeout_tx) ? S_NEXT : S_WAIT;
				S_NEXT: state <= finish_head ? S_DONE : S_HEAD;
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// words handled so far
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_head <= '0;
		else if (state == S_HEAD)
			cnt_head <= cnt_head + 1'b1;
		else if (state == S_DONE)
			cnt_head <= '0;
	end

	assign finish_head = (cnt_head == CW'(HEAD_WORDS));

	// --------------------
	// wait timeout
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_wait <= '0;
		else if (state == S_WAIT)
			cnt_wait <= cnt_wait + 16'h1;
		else
			cnt_wait <= '0;
	end

	assign timeout_tx = (cnt_wait == TIMEOUT);

	// word given up without an answer
	assign head_timeout = (state == S_WAIT) && timeout_tx && !done_tx;

	assign done_head = (state == S_DONE);
	assign fire_tx = (state == S_FIRE);
	assign data_tx = (state == S_FIRE) ? HEAD_PATTERN : '0;

endmodule

// File: logic/commu_data.sv
// payload sender: req/ack fetch per word, then fire/done with a wait timeout
module commu_data import commu_frame_pkg::*, commu_link_pkg::*; #(
	parameter int          DATA_WORDS = DATA_WORDS_DEF,
	parameter logic [15:0] TIMEOUT    = TIMEOUT_DEF
) (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  fire_data,
	output logic  done_data,
	output logic  data_timeout,
	output logic  pay_req,
	input  logic  pay_ack,
	input  word_t pay_data,
	output logic  fire_tx,
	input  logic  done_tx,
	output word_t data_tx
);

	localparam int CW = $clog2(DATA_WORDS + 1);

	typedef enum logic [2:0] {
		S_IDLE = 3'h0,
		S_REL  = 3'h1,
		S_REQ  = 3'h2,
		S_FIRE = 3'h3,
		S_WAIT = 3'h4,
		S_NEXT = 3'h5,
		S_DONE = 3'h7
	} state_t;

	state_t state;
	logic [CW-1:0] cnt_data;
	logic [15:0] cnt_wait;
	logic finish_data;
	logic timeout_tx;
	word_t data_word;

	// --------------------
	// main fsm
	// --------------------
	// each word: wait for ack low, request, then send
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: state <= fire_data ? S_REL : S_IDLE;
				S_REL: state <= pay_ack ? S_REL : S_REQ;
				S_REQ: state <= pay_ack ? S_FIRE : S_REQ;
				S_FIRE: state <= S_WAIT;
				S_WAIT: state <= (done_tx || timeout_tx) ? S_NEXT : S_WAIT;
				S_NEXT: state <= finish_data ? S_DONE : S_REL;
				S_DONE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_data <= '0;
		else if (state == S_FIRE)
			cnt_data <= cnt_data + 1'b1;
		else if (state == S_DONE)
			cnt_data <= '0;
	end

	assign finish_data = (cnt_data == CW'(DATA_WORDS));

	// fetched word, held until the next fetch
	always_ff @(posedge clk_sys) begin
		if (state == S_REQ && pay_ack)
			data_word <= pay_data;
	end

	// --------------------
	// wait timeout
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			cnt_wait <= '0;
		else if (state == S_WAIT)
			cnt_wait <= cnt_wait + 16'h1;
		else
			cnt_wait <= '0;
	end

	assign timeout_tx = (cnt_wait == TIMEOUT);
	assign data_timeout = (state == S_WAIT) && timeout_tx && !done_tx;

	// source may hold ack as long as it likes, no timeout here
	assign pay_req = (state == S_REQ);

	assign done_data = (state == S_DONE);
	assign fire_tx = (state == S_FIRE);
	assign data_tx = data_word;

endmodule

// File: logic/commu_tx.sv
// serial transmitter: start bit, 16 data bits lsb first, stop bit, gated by cts
module commu_tx import commu_frame_pkg::*, commu_link_pkg::*; #(
	parameter int BIT_CYCLES = BIT_CYCLES_DEF
) (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  fire_tx,
	input  word_t data_tx,
	output logic  done_tx,
	input  logic  cts,
	output logic  ser_out
);

	localparam int FRAME_BITS = $bits(word_t) + 2;
	localparam int BCW = $clog2(FRAME_BITS);
	localparam int TCW = $clog2(BIT_CYCLES + 1);

	logic busy;
	logic [FRAME_BITS-1:0] shift_reg;
	logic [TCW-1:0] cnt_tick;
	logic [BCW-1:0] cnt_bit;
	logic start_word;
	logic bit_end;
	logic last_bit;

	// cts only matters at the fire pulse
	assign start_word = !busy && fire_tx && cts;
	assign bit_end = (cnt_tick == TCW'(BIT_CYCLES - 1));
	assign last_bit = (cnt_bit == BCW'(FRAME_BITS - 1));

	// --------------------
	// bit timing
	// --------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt_tick <= '0;
			cnt_bit <= '0;
			done_tx <= 1'b0;
		end else begin
			done_tx <= 1'b0;
			if (start_word) begin
				busy <= 1'b1;
				cnt_tick <= '0;
				cnt_bit <= '0;
			end else if (busy && bit_end) begin
				cnt_tick <= '0;
				if (last_bit) begin
					// stop bit finished
					busy <= 1'b0;
					done_tx <= 1'b1;
				end else begin
					cnt_bit <= cnt_bit + 1'b1;
				end
			end else if (busy) begin
				cnt_tick <= cnt_tick + 1'b1;
			end
		end
	end

	// stop, data, start from msb down
	always_ff @(posedge clk_sys) begin
		if (start_word)
			shift_reg <= {1'b1, data_tx, 1'b0};
		else if (busy && bit_end)
			shift_reg <= {1'b1, shift_reg[FRAME_BITS-1:1]};
	end

	// line idles high
	assign ser_out = busy ? shift_reg[0] : 1'b1;

endmodule

// File: logic/commu_main.sv
// frame sequencer: header then payload, transmitter source, sticky timeout flag
module commu_main import commu_link_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  logic    start,
	output logic    fire_head,
	input  logic    done_head,
	input  logic    head_timeout,
	output logic    fire_data,
	input  logic    done_data,
	input  logic    data_timeout,
	output tx_src_t tx_src,
	output logic    frame_done,
	output logic    frame_timeout
);

	typedef enum logic [1:0] {
		M_IDLE = 2'h0,
		M_HEAD = 2'h1,
		M_DATA = 2'h2
	} mstate_t;

	mstate_t state;

	// --------------------
	// frame fsm
	// --------------------
	// start is ignored outside idle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= M_IDLE;
		end else begin
			case (state)
				M_IDLE: state <= start ? M_HEAD : M_IDLE;
				M_HEAD: state <= done_head ? M_DATA : M_HEAD;
				M_DATA: state <= done_data ? M_IDLE : M_DATA;
				default: state <= M_IDLE;
			endcase
		end
	end

	assign fire_head = (state == M_IDLE) && start;
	assign fire_data = (state == M_HEAD) && done_head;
	assign frame_done = (state == M_DATA) && done_data;
	assign tx_src = (state == M_DATA) ? SRC_DATA : SRC_HEAD;

	// sticky until the next frame starts
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			frame_timeout <= 1'b0;
		else if (fire_head)
			frame_timeout <= 1'b0;
		else if (head_timeout || data_timeout)
			frame_timeout <= 1'b1;
	end

endmodule

// File: logic/commu_top.sv
// top level: sequencer, header and payload senders, shared serial transmitter
module commu_top import commu_frame_pkg::*, commu_link_pkg::*; #(
	parameter int          HEAD_WORDS = HEAD_WORDS_DEF,
	parameter int          DATA_WORDS = DATA_WORDS_DEF,
	parameter int          BIT_CYCLES = BIT_CYCLES_DEF,
	parameter logic [15:0] TIMEOUT    = TIMEOUT_DEF
) (
	input  logic  clk_sys,
	input  logic  rst_n,
	input  logic  start,
	input  logic  cts,
	output logic  pay_req,
	input  logic  pay_ack,
	input  word_t pay_data,
	output logic  ser_out,
	output logic  frame_done,
	output logic  frame_timeout
);

	logic fire_head, done_head, head_timeout;
	logic fire_data, done_data, data_timeout;
	logic fire_tx_head, fire_tx_data, fire_tx, done_tx;
	word_t data_tx_head, data_tx_data, data_tx;
	tx_src_t tx_src;

	commu_main u_main (
		.clk_sys(clk_sys), .rst_n(rst_n), .start(start),
		.fire_head(fire_head), .done_head(done_head), .head_timeout(head_timeout),
		.fire_data(fire_data), .done_data(done_data), .data_timeout(data_timeout),
		.tx_src(tx_src), .frame_done(frame_done), .frame_timeout(frame_timeout)
	);

	commu_head #(.HEAD_WORDS(HEAD_WORDS), .TIMEOUT(TIMEOUT)) u_head (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_head(fire_head), .done_head(done_head),
		.head_timeout(head_timeout), .fire_tx(fire_tx_head), .done_tx(done_tx),
		.data_tx(data_tx_head)
	);

	commu_data #(.DATA_WORDS(DATA_WORDS), .TIMEOUT(TIMEOUT)) u_data (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_data(fire_data), .done_data(done_data),
		.data_timeout(data_timeout), .pay_req(pay_req), .pay_ack(pay_ack),
		.pay_data(pay_data), .fire_tx(fire_tx_data), .done_tx(done_tx),
		.data_tx(data_tx_data)
	);

	// transmitter follows whichever sender owns the frame phase
	assign fire_tx = (tx_src == SRC_DATA) ? fire_tx_data : fire_tx_head;
	assign data_tx = (tx_src == SRC_DATA) ? data_tx_data : data_tx_head;

	commu_tx #(.BIT_CYCLES(BIT_CYCLES)) u_tx (
		.clk_sys(clk_sys), .rst_n(rst_n), .fire_tx(fire_tx), .data_tx(data_tx),
		.done_tx(done_tx), .cts(cts), .ser_out(ser_out)
	);

endmodule

// File: verif/commu_assertions.sv
// handshake assertions for commu_top: payload req/ack order, frame_done width
module commu_assertions (
	input logic clk_sys,
	input logic rst_n,
	input logic pay_req,
	input logic pay_ack,
	input logic frame_done
);
	timeunit 1ns;
	timeprecision 1ps;

	// number of failed assertions
	int fail_count;

	initial fail_count = 0;

	// --------------------
	// payload four-phase
	// --------------------
	// req only drops after ack was seen
	req_held: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(pay_req) |-> $past(pay_ack))
		else begin
			fail_count++;
			$error("pay_req fell before pay_ack rose");
		end

	// no new request while ack is still up
	req_after_release: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(pay_req) |-> !$past(pay_ack))
		else begin
			fail_count++;
			$error("pay_req rose while pay_ack was high");
		end

	// single cycle pulse
	done_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		frame_done |=> !frame_done)
		else begin
			fail_count++;
			$error("frame_done longer than one cycle");
		end

endmodule

bind commu_top commu_assertions u_assertions (
	.clk_sys(clk_sys), .rst_n(rst_n), .pay_req(pay_req), .pay_ack(pay_ack),
	.frame_done(frame_done)
);

// File: verif/commu_tb.sv
// testbench for commu_top: clock, reset, payload source model, serial decoder, table checks
module commu_tb import commu_frame_pkg::*, commu_link_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int HEAD_WORDS = 3;
	localparam int DATA_WORDS = 4;
	localparam int BIT_CYCLES = 4;
	localparam logic [15:0] TIMEOUT = 16'd120;
	localparam int N_ROWS = 4;

	// table columns are cts, payload base, expected frame_timeout, expected words, max ack delay
	logic row_cts [N_ROWS] = '{1'b1, 1'b1, 1'b0, 1'b1};
	word_t row_base [N_ROWS] = '{16'h1234, 16'hA5F0, 16'h0F00, 16'h7FFE};
	logic row_tmo [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0};
	int row_count [N_ROWS] = '{7, 7, 0, 7};
	int row_delay [N_ROWS] = '{3, 3, 3, 40};

	logic clk_sys, rst_n, start, cts, pay_req, pay_ack, ser_out, frame_done, frame_timeout;
	word_t pay_data;
	word_t cur_base;
	word_t rx_words[$];
	int cur_delay, delay_left, pay_idx, errors, checks;
	logic line_fell;
	integer seed = 32'h269e_bb0f;

	commu_top #(.HEAD_WORDS(HEAD_WORDS), .DATA_WORDS(DATA_WORDS), .BIT_CYCLES(BIT_CYCLES),
		.TIMEOUT(TIMEOUT)) UUT (
		.clk_sys(clk_sys), .rst_n(rst_n), .start(start), .cts(cts), .pay_req(pay_req),
		.pay_ack(pay_ack), .pay_data(pay_data), .ser_out(ser_out), .frame_done(frame_done),
		.frame_timeout(frame_timeout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	// --------------------
	// payload source
	// --------------------
	// ack after a random delay, dropped once req falls
	always @(negedge clk_sys) begin
		if (!rst_n) begin
			pay_ack = 1'b0;
		end else if (pay_ack && !pay_req) begin
			pay_ack = 1'b0;
			delay_left = $unsigned($random(seed)) % (cur_delay + 1);
		end else if (pay_req && !pay_ack) begin
			if (delay_left == 0) begin
				pay_data = cur_base + word_t'(pay_idx);
				pay_ack = 1'b1;
				pay_idx++;
			end else begin
				delay_left--;
			end
		end
	end

	// --------------------
	// serial decoder
	// --------------------
	initial begin
		word_t rx_word;
		forever begin
			@(negedge clk_sys);
			if (rst_n === 1'b1 && ser_out === 1'b0) begin
				line_fell = 1'b1;
				// middle of the start bit
				repeat (BIT_CYCLES / 2) @(negedge clk_sys);
				for (int b = 0; b < $bits(word_t); b++) begin
					repeat (BIT_CYCLES) @(negedge clk_sys);
					rx_word[b] = ser_out;
				end
				repeat (BIT_CYCLES) @(negedge clk_sys);
				if (ser_out !== 1'b1) begin
					$display("stop bit missing after word %h", rx_word);
					errors++;
				end
				rx_words.push_back(rx_word);
			end
		end
	end

	initial begin
		int bound, cycles, errs_before;
		bit hung;
		word_t exp_word;
		rst_n = 1'b0;
		start = 1'b0;
		cts = 1'b1;
		pay_ack = 1'b0;
		pay_data = '0;
		cur_base = '0;
		cur_delay = 0;
		delay_left = 0;
		pay_idx = 0;
		errors = 0;
		checks = 0;
		line_fell = 1'b0;
		hung = 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		rst_n = 1'b1;

		// test 0: idle state after reset
		@(negedge clk_sys);
		compare_value("ser_out", ser_out, 1'b1);
		compare_value("frame_done", frame_done, 1'b0);
		compare_value("pay_req", pay_req, 1'b0);
		$display("test 0 reset state: %s", (errors == 0) ? "pass" : "FAIL");

		for (int r = 0; r < N_ROWS && !hung; r++) begin
			errs_before = errors;
			cts = row_cts[r];
			cur_base = row_base[r];
			cur_delay = row_delay[r];
			pay_idx = 0;
			delay_left = $unsigned($random(seed)) % (cur_delay + 1);
			line_fell = 1'b0;
			rx_words.delete();
			bound = (HEAD_WORDS + DATA_WORDS) * (TIMEOUT + 4)
				+ DATA_WORDS * (cur_delay + 4) + 16;
			start = 1'b1;
			@(negedge clk_sys);
			start = 1'b0;
			cycles = 0;
			while (frame_done !== 1'b1 && cycles < bound) begin
				@(negedge clk_sys);
				cycles++;
			end
			if (frame_done !== 1'b1) begin
				$display("frame %0d: frame_done did not arrive within %0d cycles", r, bound);
				errors++;
				hung = 1'b1;
			end else begin
				compare_value("frame_timeout", frame_timeout, row_tmo[r]);
				compare_value("word count", rx_words.size(), row_count[r]);
				for (int i = 0; i < rx_words.size() && i < row_count[r]; i++) begin
					exp_word = (i < HEAD_WORDS) ? HEAD_PATTERN
						: row_base[r] + word_t'(i - HEAD_WORDS);
					compare_value($sformatf("ser_out word %0d", i), rx_words[i], exp_word);
				end
				if (!row_cts[r] && line_fell) begin
					$display("frame %0d: serial line went low while cts was low", r);
					errors++;
				end
			end
			$display("test %0d frame base %h cts %b: %s", r + 1, row_base[r], row_cts[r],
				(errors == errs_before) ? "pass" : "FAIL");
			repeat (4) @(negedge clk_sys);
		end

		errors += UUT.u_assertions.fail_count;
		$display("tests %0d, checks %0d, errors %0d", N_ROWS + 1, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: commu.f
logic/commu_frame_pkg.sv
logic/commu_link_pkg.sv
logic/commu_head.sv
logic/commu_data.sv
logic/commu_tx.sv
logic/commu_main.sv
logic/commu_top.sv
verif/commu_assertions.sv
verif/commu_tb.sv

// File: Bender.yml
package:
  name: commu

sources:
  - logic/commu_frame_pkg.sv
  - logic/commu_link_pkg.sv
  - logic/commu_head.sv
  - logic/commu_data.sv
  - logic/commu_tx.sv
  - logic/commu_main.sv
  - logic/commu_top.sv
  - target: simulation
    files:
      - verif/commu_assertions.sv
      - verif/commu_tb.sv
